// File: gpu_golden.txt
// host writes as {select, value}, select in the upper byte, lcdc last
// then tile bytes from 0x8000 (low plane, high plane per row), then fb words 0..3
0112
0234
0456
051B
0678
079A
0091
00FF
0000
0000
00FF
000F
0033
00A5
003C
AAAA
5555
F5A0
B14E

// File: build.f
+incdir+.
gpuPkg.sv
gpuIfs.sv
gpuDecode.sv
gpuExecute.sv
gpuResult.sv
gpuTop.sv
gpuTb_chk.sv
gpuTb.sv

// File: gpuTb.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuTb;

  localparam int HalfPeriod    = 50;
  localparam int DriveDelay    = 10;                    // inputs move this long after posedge
  localparam int RstCycles     = 10;
  localparam int Seed          = 128;
  localparam int HostWrites    = 7;
  localparam int MemBytes      = 2 * `ROW_COUNT;
  localparam int FbBase        = HostWrites + MemBytes; // first expected fb word
  localparam int GoldenWords   = FbBase + `ROW_COUNT;
  localparam int QuietCycles   = 50;
  localparam int TimeoutCycles = RstCycles + 2 * HostWrites + `ROW_COUNT * 40 + QuietCycles;

  logic                   clock;
  logic                   rstN;
  logic [`HOST_SEL_W-1:0] mcuRegSelect;
  logic [`BYTE_W-1:0]     mcuWriteData;
  logic                   mcuWe;
  logic [`BYTE_W-1:0]     mcuReadData;
  logic [`DATA_W-1:0]     mcuAddr;
  logic                   mcuReadRequest;
  logic                   fbWe;
  logic [`FB_ADDR_W-1:0]  fbAddr;
  logic [`DATA_W-1:0]     fbData;
  logic                   fbCreditReturn;
  logic [`BYTE_W-1:0]     lcdc;
  logic [`BYTE_W-1:0]     scy;
  logic [`BYTE_W-1:0]     scx;
  logic [`BYTE_W-1:0]     ly;
  logic [`BYTE_W-1:0]     lyc;
  logic [`BYTE_W-1:0]     bgp;
  logic [`BYTE_W-1:0]     wy;
  logic [`BYTE_W-1:0]     wx;

  logic [15:0]        golden [0:GoldenWords-1];
  int                 errorCount  = 0;
  int                 checkCount  = 0;
  int                 fbCount     = 0;     // fb words seen so far
  int                 readCount   = 0;     // vmem requests seen so far
  int                 outstanding = 0;     // credits taken and not yet returned
  int                 idleLeft    = 0;     // cycles before the next return
  logic               readPending = 1'b0;
  logic [`DATA_W-1:0] readAddr;

  gpuTop dut_i (
    .clock          (clock),
    .rstN           (rstN),
    .mcuRegSelect   (mcuRegSelect),
    .mcuWriteData   (mcuWriteData),
    .mcuWe          (mcuWe),
    .mcuReadData    (mcuReadData),
    .mcuAddr        (mcuAddr),
    .mcuReadRequest (mcuReadRequest),
    .fbWe           (fbWe),
    .fbAddr         (fbAddr),
    .fbData         (fbData),
    .fbCreditReturn (fbCreditReturn),
    .lcdc           (lcdc),
    .scy            (scy),
    .scx            (scx),
    .ly             (ly),
    .lyc            (lyc),
    .bgp            (bgp),
    .wy             (wy),
    .wx             (wx)
  );

  initial clock = 1'b0;
  always #HalfPeriod clock = ~clock;

  ////////////////////////////////////////
  // helpers

  task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // pixel 7 shifted in first so it ends in the top bits
  function automatic logic [15:0] paletteWord(logic [7:0] lo, logic [7:0] hi, logic [7:0] pal);
    logic [15:0] w;
    logic [1:0]  color;
    w = '0;
    for (int p = 7; p >= 0; p--)
    begin
      color = {hi[p], lo[p]};
      w     = {w[13:0], pal[color * 2 +: 2]};
    end
    return w;
  endfunction

  function automatic logic [7:0] displayReg(logic [3:0] sel);
    case (sel)
      0:       return lcdc;
      1:       return scy;
      2:       return scx;
      3:       return ly;
      4:       return lyc;
      5:       return bgp;
      6:       return wy;
      7:       return wx;
      default: return 8'h00;
    endcase
  endfunction

  task automatic hostWrite(logic [3:0] sel, logic [7:0] value);
    @(posedge clock);
    #DriveDelay;
    mcuRegSelect = sel;
    mcuWriteData = value;
    mcuWe        = 1'b1;
    @(posedge clock);                 // lands here
    #DriveDelay;
    mcuWe = 1'b0;
  endtask

  ////////////////////////////////////////
  // bus monitor sampled mid-cycle

  always @(negedge clock)
  begin
    if (rstN)
    begin
      if (mcuReadRequest)
      begin
        checkValue($sformatf("read address %0d", readCount),
                   16'(`VMEM_BASE + readCount), mcuAddr);
        readPending = 1'b1;           // answered after the next posedge
        readAddr    = mcuAddr;
        readCount++;
      end
      if (fbWe)
      begin
        checkCount++;
        assert (outstanding < `FB_CREDITS)
        else
        begin
          errorCount++;
          $display("framebuffer write issued while every credit was outstanding");
        end
        if (fbCount < `ROW_COUNT)
        begin
          checkValue($sformatf("fb address %0d", fbCount), 16'(fbCount), 16'(fbAddr));
          checkValue($sformatf("fb data %0d", fbCount), golden[FbBase + fbCount], fbData);
        end
        else
        begin
          errorCount++;
          $display("framebuffer write beyond the last row");
        end
        outstanding++;
        fbCount++;
      end
    end
  end

  // vmem answer and credit return driven after the edge
  always @(posedge clock)
  begin : drivePorts
    int idx;
    #DriveDelay;
    if (rstN)
    begin
      if (readPending)
      begin
        idx = int'(readAddr) - `VMEM_BASE;
        if (idx >= 0 && idx < MemBytes)
          mcuReadData = golden[HostWrites + idx][7:0];
        else
        begin
          errorCount++;
          $display("vmem read outside the tile data at address %h", readAddr);
        end
        readPending = 1'b0;           // byte holds until the next request
      end
      fbCreditReturn = 1'b0;
      if (outstanding > 0)
      begin
        if (idleLeft == 0)
        begin
          fbCreditReturn = 1'b1;
          outstanding--;
          idleLeft = $urandom % 6;    // 0..5 idle cycles before the next one
        end
        else
          idleLeft--;
      end
    end
  end

  ////////////////////////////////////////
  // main sequence

  initial
  begin : mainSeq
    logic [7:0] pal;
    void'($urandom(Seed));
    rstN           = 1'b0;
    mcuRegSelect   = '0;
    mcuWriteData   = '0;
    mcuWe          = 1'b0;
    mcuReadData    = '0;
    fbCreditReturn = 1'b0;
    idleLeft       = $urandom % 6;
    pal            = 8'h00;
    $readmemh("gpu_golden.txt", golden);

    checkCount++;
    assert (!$isunknown(golden[GoldenWords-1]))
    else
    begin
      errorCount++;
      $display("golden file missing or shorter than %0d words", GoldenWords);
    end

    // golden words must follow the palette rule
    for (int i = 0; i < HostWrites; i++)
      if (golden[i][11:8] == 4'd5)
        pal = golden[i][7:0];
    for (int k = 0; k < `ROW_COUNT; k++)
      checkValue($sformatf("golden word %0d", k),
                 paletteWord(golden[HostWrites + 2*k][7:0],
                             golden[HostWrites + 2*k + 1][7:0], pal),
                 golden[FbBase + k]);

    repeat (RstCycles) @(posedge clock);
    #DriveDelay;
    rstN = 1'b1;
    @(negedge clock);
    checkValue("reset fbWe", 16'h0, 16'(fbWe));
    checkValue("reset mcuReadRequest", 16'h0, 16'(mcuReadRequest));
    for (int s = 0; s < 8; s++)
      checkValue($sformatf("reset register %0d", s), 16'h0, 16'(displayReg(4'(s))));

    // display registers with lcdc last to start the engine
    for (int i = 0; i < HostWrites; i++)
    begin
      hostWrite(golden[i][11:8], golden[i][7:0]);
      @(negedge clock);
      checkValue($sformatf("host register %0d", golden[i][11:8]), 16'(golden[i][7:0]),
                 16'(displayReg(golden[i][11:8])));
    end

    while (ly != `ROW_COUNT)
      @(negedge clock);
    repeat (QuietCycles) @(negedge clock);   // nothing more should be written
    checkValue("final ly", 16'(`ROW_COUNT), 16'(ly));
    checkValue("fb word count", 16'(`ROW_COUNT), 16'(fbCount));
    checkValue("vmem read count", 16'(MemBytes), 16'(readCount));

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // watchdog
  initial
  begin : watchdog
    repeat (TimeoutCycles) @(posedge clock);
    errorCount++;
    $display("timeout: render did not finish within %0d cycles", TimeoutCycles);
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    $display("test failed");
    $finish;
  end

endmodule

// File: gpuTb_chk.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuTb_chk
(
  input logic                 clock,
  input logic                 rstN,
  input logic [`CREDIT_W-1:0] credits,
  input logic                 fbWe,
  input logic                 mcuReadRequest
);

  ////////////////////////////////////////
  // framebuffer credits

  // returns never push the count past the starting pool
  creditLimit: assert property (@(posedge clock) disable iff (!rstN)
    credits <= `CREDIT_W'(`FB_CREDITS))
    else $error("credit count went above the initial pool");

  // a write only goes out while a credit is held
  writeNeedsCredit: assert property (@(posedge clock) disable iff (!rstN)
    $rose(fbWe) |-> credits != '0)
    else $error("fbWe rose with no credit left");

  ////////////////////////////////////////
  // vmem read strobe

  readPulse: assert property (@(posedge clock) disable iff (!rstN)
    mcuReadRequest |=> !mcuReadRequest)    // one cycle per rvmem
    else $error("mcuReadRequest held longer than one cycle");

endmodule

bind gpuResult gpuTb_chk chk_i (
  .clock          (clock),
  .rstN           (rstN),
  .credits        (credits),
  .fbWe           (fbWe),
  .mcuReadRequest (mcuReadRequest)
);

// File: gpuTop.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuTop
(
  input  logic                   clock,
  input  logic                   rstN,
  // host / vmem bus
  input  logic [`HOST_SEL_W-1:0] mcuRegSelect,
  input  logic [`BYTE_W-1:0]     mcuWriteData,
  input  logic                   mcuWe,
  input  logic [`BYTE_W-1:0]     mcuReadData,
  output logic [`DATA_W-1:0]     mcuAddr,
  output logic                   mcuReadRequest,
  // framebuffer
  output logic                   fbWe,
  output logic [`FB_ADDR_W-1:0]  fbAddr,
  output logic [`DATA_W-1:0]     fbData,
  input  logic                   fbCreditReturn,
  // display registers
  output logic [`BYTE_W-1:0]     lcdc,
  output logic [`BYTE_W-1:0]     scy,
  output logic [`BYTE_W-1:0]     scx,
  output logic [`BYTE_W-1:0]     ly,
  output logic [`BYTE_W-1:0]     lyc,
  output logic [`BYTE_W-1:0]     bgp,
  output logic [`BYTE_W-1:0]     wy,
  output logic [`BYTE_W-1:0]     wx
);

  logic creditAvail;    // result -> execute

  uopIf     uopBus ();
  regPortIf regBus ();

  ////////////////////////////////////////
  // sequencer, alu, register bank

  gpuDecode decode_i (
    .clock   (clock),
    .rstN    (rstN),
    .active  (lcdc[7]),            // engine runs while lcdc bit 7 set
    .uopPort (uopBus.decode)
  );

  gpuExecute execute_i (
    .uopPort     (uopBus.execute),
    .regPort     (regBus.execute),
    .creditAvail (creditAvail)
  );

  gpuResult result_i (
    .clock          (clock),
    .rstN           (rstN),
    .regPort        (regBus.resultStage),
    .mcuRegSelect   (mcuRegSelect),
    .mcuWriteData   (mcuWriteData),
    .mcuWe          (mcuWe),
    .mcuReadData    (mcuReadData),
    .mcuAddr        (mcuAddr),
    .mcuReadRequest (mcuReadRequest),
    .fbWe           (fbWe),
    .fbAddr         (fbAddr),
    .fbData         (fbData),
    .fbCreditReturn (fbCreditReturn),
    .creditAvail    (creditAvail),
    .lcdc           (lcdc),
    .scy            (scy),
    .scx            (scx),
    .ly             (ly),
    .lyc            (lyc),
    .bgp            (bgp),
    .wy             (wy),
    .wx             (wx)
  );

endmodule

// File: gpuResult.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuResult
  import gpuPkg::*;
(
  input  logic                  clock,
  input  logic                  rstN,
  regPortIf.resultStage         regPort,
  input  logic [`HOST_SEL_W-1:0] mcuRegSelect,
  input  logic [`BYTE_W-1:0]    mcuWriteData,
  input  logic                  mcuWe,
  input  logic [`BYTE_W-1:0]    mcuReadData,
  output logic [`DATA_W-1:0]    mcuAddr,
  output logic                  mcuReadRequest,
  output logic                  fbWe,
  output logic [`FB_ADDR_W-1:0] fbAddr,
  output logic [`DATA_W-1:0]    fbData,
  input  logic                  fbCreditReturn,
  output logic                  creditAvail,
  output logic [`BYTE_W-1:0]    lcdc,
  output logic [`BYTE_W-1:0]    scy,
  output logic [`BYTE_W-1:0]    scx,
  output logic [`BYTE_W-1:0]    ly,
  output logic [`BYTE_W-1:0]    lyc,
  output logic [`BYTE_W-1:0]    bgp,
  output logic [`BYTE_W-1:0]    wy,
  output logic [`BYTE_W-1:0]    wx
);

  logic [`DATA_W-1:0]    vmemAddr;
  logic [`BYTE_W-1:0]    bh;              // high bitplane
  logic [`BYTE_W-1:0]    bl;              // low bitplane
  logic [`DATA_W-1:0]    r0;
  logic [`DATA_W-1:0]    r1;
  logic [`DATA_W-1:0]    r2;
  logic [`DATA_W-1:0]    r3;
  logic                  zeroFlag;
  logic [`FB_ADDR_W-1:0] fbAddrCnt;       // next fb word
  logic [`CREDIT_W-1:0]  credits;
  logic [`DATA_W-1:0]    pixWord;         // 8 converted pixels
  gpuReg_t               hostSel;

  ////////////////////////////////////////
  // host side display registers

  assign hostSel = gpuReg_t'({1'b0, mcuRegSelect});

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      lcdc <= '0;
      scy  <= '0;
      scx  <= '0;
      lyc  <= '0;
      bgp  <= '0;
      wy   <= '0;
      wx   <= '0;
    end
    else if (mcuWe)
    begin
      case (hostSel)
        regLcdc: lcdc <= mcuWriteData;    // bit 7 starts the engine
        regScy:  scy  <= mcuWriteData;
        regScx:  scx  <= mcuWriteData;
        regLyc:  lyc  <= mcuWriteData;
        regBgp:  bgp  <= mcuWriteData;
        regWy:   wy   <= mcuWriteData;
        regWx:   wx   <= mcuWriteData;
        default: ;                        // ly stays engine only
      endcase
    end
  end

  // engine side registers and zero flag
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      ly       <= '0;
      vmemAddr <= '0;
      bh       <= '0;
      bl       <= '0;
      r0       <= '0;
      r1       <= '0;
      r2       <= '0;
      r3       <= '0;
      zeroFlag <= 1'b0;
    end
    else if (regPort.regWe)
    begin
      zeroFlag <= (regPort.result == '0);   // any register write updates it
      case (regPort.dst)
        regLy:       ly       <= regPort.result[`BYTE_W-1:0];
        regVmemAddr: vmemAddr <= regPort.result;
        regBh:       bh       <= regPort.result[`BYTE_W-1:0];
        regBl:       bl       <= regPort.result[`BYTE_W-1:0];
        regR0:       r0       <= regPort.result;
        regR1:       r1       <= regPort.result;
        regR2:       r2       <= regPort.result;
        regR3:       r3       <= regPort.result;
        default: ;
      endcase
    end
  end

  // shared read mux
  function automatic logic [`DATA_W-1:0] readReg(gpuReg_t sel);
    logic [`DATA_W-1:0] v;
    case (sel)
      regLcdc:     v = `DATA_W'(lcdc);
      regScy:      v = `DATA_W'(scy);
      regScx:      v = `DATA_W'(scx);
      regLy:       v = `DATA_W'(ly);
      regLyc:      v = `DATA_W'(lyc);
      regBgp:      v = `DATA_W'(bgp);
      regWy:       v = `DATA_W'(wy);
      regWx:       v = `DATA_W'(wx);
      regVmemAddr: v = vmemAddr;
      regBh:       v = `DATA_W'(bh);
      regBl:       v = `DATA_W'(bl);
      regR0:       v = r0;
      regR1:       v = r1;
      regR2:       v = r2;
      regR3:       v = r3;
      regFbAddr:   v = `DATA_W'(fbAddrCnt);
      regReadData: v = `DATA_W'(mcuReadData);   // live bus byte
      default:     v = '0;
    endcase
    return v;
  endfunction

  always_comb
  begin
    regPort.srcValue = readReg(regPort.src);
    regPort.dstValue = readReg(regPort.dst);
  end

  assign regPort.zero = zeroFlag;

  // vmem read port
  assign mcuAddr        = vmemAddr;
  assign mcuReadRequest = regPort.readReq;

  ////////////////////////////////////////
  // palette conversion, pixel 7 in the top bits

  always_comb
  begin
    for (int i = 0; i < `BYTE_W; i++)
      pixWord[2*i +: 2] = bgp[2*{bh[i], bl[i]} +: 2];   // color index picks bgp field
  end

  // framebuffer write, one cycle after wbg
  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
    begin
      fbWe      <= 1'b0;
      fbAddrCnt <= '0;
    end
    else
    begin
      fbWe <= regPort.bufWe;
      if (regPort.bufWe)
        fbAddrCnt <= fbAddrCnt + 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (regPort.bufWe)
    begin
      fbAddr <= fbAddrCnt;
      fbData <= pixWord;
    end
  end

  ////////////////////////////////////////
  // credits
  // spent when fbWe goes out, returned one per fbCreditReturn cycle

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
      credits <= `CREDIT_W'(`FB_CREDITS);
    else if (fbWe != fbCreditReturn)                  // both at once cancel
      credits <= fbWe ? credits - 1'b1 : credits + 1'b1;
  end

  // the write already on the bus still holds its credit
  assign creditAvail = credits > `CREDIT_W'(fbWe);

endmodule

// File: gpuExecute.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuExecute
  import gpuPkg::*;
(
  uopIf.execute     uopPort,
  regPortIf.execute regPort,
  input logic       creditAvail      // fb credit free for a new write
);

  uop_t               uop;
  logic               valid;
  logic [`DATA_W-1:0] litValue;       // zero extended literal
  logic               writes;         // op writes dst
  logic               isWbg;
  logic               reads;          // op is rvmem
  logic               jumpCond;

  assign uop      = uopPort.uop;
  assign valid    = uopPort.uopValid;
  assign litValue = `DATA_W'(uop.arg.literal);

  ////////////////////////////////////////
  // alu and control decode

  always_comb
  begin
    regPort.result = '0;
    writes         = 1'b0;
    isWbg          = 1'b0;
    reads          = 1'b0;
    jumpCond       = 1'b0;
    case (uop.op)
      opNop: ;
      opWbg:
        isWbg = 1'b1;
      opWrr:
      begin
        regPort.result = regPort.srcValue;
        writes         = 1'b1;
      end
      opWrl:
      begin
        // literal lands in the top bits so a page base fits one word
        regPort.result = {uop.arg.literal, {(`DATA_W - `LIT_W){1'b0}}};
        writes         = 1'b1;
      end
      opRvmem:
        reads = 1'b1;                                  // data back next edge
      opAdd:
      begin
        regPort.result = regPort.dstValue + regPort.srcValue;
        writes         = 1'b1;
      end
      opAddl:
      begin
        regPort.result = regPort.dstValue + litValue;
        writes         = 1'b1;
      end
      opSubl:
      begin
        regPort.result = regPort.dstValue - litValue;
        writes         = 1'b1;
      end
      opSub:
      begin
        regPort.result = regPort.dstValue - regPort.srcValue;
        writes         = 1'b1;
      end
      opAnd:
      begin
        regPort.result = regPort.dstValue & regPort.srcValue;
        writes         = 1'b1;
      end
      opJz:   jumpCond = regPort.zero;
      opJnz:  jumpCond = ~regPort.zero;
      opGoto: jumpCond = 1'b1;
      default: ;                                       // unknown op does nothing
    endcase
  end

  assign regPort.dst     = uop.dst;
  assign regPort.src     = uop.arg.r.src;    // meaningless in literal forms, unused there
  assign regPort.regWe   = valid & writes;
  assign regPort.readReq = valid & reads;

  // back-pressure
  assign uopPort.holdReq = isWbg & ~creditAvail;
  assign regPort.bufWe   = valid & isWbg & ~uopPort.stall;

  assign uopPort.jump       = valid & jumpCond;
  assign uopPort.jumpTarget = uop.arg.literal[`PC_W-1:0];

endmodule

// File: gpuDecode.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

module gpuDecode
  import gpuPkg::*;
(
  input logic  clock,
  input logic  rstN,
  input logic  active,       // lcdc bit 7
  uopIf.decode uopPort
);

  localparam int RomAddrW = $clog2(`UCODE_DEPTH);

  localparam logic [`DATA_W-1:0] VmemBase = `VMEM_BASE;
  localparam logic [`LIT_W-1:0]  BasePage = VmemBase[`DATA_W-1 -: `LIT_W];  // wrl fills top bits
  localparam logic [`LIT_W-1:0]  RowCount = `ROW_COUNT;
  localparam logic [`PC_W-1:0]   LoopPc   = 8'd2;     // top of tile row loop
  localparam logic [`PC_W-1:0]   ParkPc   = 8'd12;    // spin here when done

  logic [`PC_W-1:0] pc;

  // register form word
  function automatic uop_t regUop(gpuOp_t op, gpuReg_t dst, gpuReg_t src);
    uop_t u;
    u.op         = op;
    u.dst        = dst;
    u.arg.r.src  = src;
    u.arg.r.rsvd = '0;
    return u;
  endfunction

  // literal / jump form word
  function automatic uop_t litUop(gpuOp_t op, gpuReg_t dst, logic [`LIT_W-1:0] lit);
    uop_t u;
    u.op          = op;
    u.dst         = dst;
    u.arg.literal = lit;
    return u;
  endfunction

  ////////////////////////////////////////
  // microprogram

  function automatic uop_t romWord(logic [RomAddrW-1:0] addr);
    uop_t w;
    case (addr)
      0:  w = litUop(opWrl, regVmemAddr, BasePage);        // point at tile data
      1:  w = litUop(opAddl, regR0, RowCount);             // loop count, r0 clear from reset
      2:  w = regUop(opRvmem, regVmemAddr, regVmemAddr);   // low plane request
      3:  w = regUop(opWrr, regBl, regReadData);
      4:  w = litUop(opAddl, regVmemAddr, 10'd1);
      5:  w = regUop(opRvmem, regVmemAddr, regVmemAddr);   // high plane request
      6:  w = regUop(opWrr, regBh, regReadData);
      7:  w = litUop(opAddl, regVmemAddr, 10'd1);
      8:  w = regUop(opWbg, regFbAddr, regFbAddr);         // may stall on credits
      9:  w = litUop(opAddl, regLy, 10'd1);
      10: w = litUop(opSubl, regR0, 10'd1);                // sets zero on last pass
      11: w = litUop(opJnz, regR0, LoopPc);
      12: w = litUop(opGoto, regR0, ParkPc);               // park
      default:
        w = litUop(opNop, regLcdc, '0);
    endcase
    return w;
  endfunction

  // uop straight off the pc, no pipeline register
  always_comb
  begin
    if (pc < `UCODE_DEPTH)
      uopPort.uop = romWord(pc[RomAddrW-1:0]);
    else
      uopPort.uop = litUop(opNop, regLcdc, '0);   // past rom end reads as nop
  end

  assign uopPort.uopValid = active;
  assign uopPort.stall    = active & uopPort.holdReq;   // wbg without a credit

  ////////////////////////////////////////
  // program counter

  always_ff @(posedge clock or negedge rstN)
  begin
    if (!rstN)
      pc <= '0;
    else if (uopPort.jump)
      pc <= uopPort.jumpTarget;                  // taken branch wins
    else if (active && !uopPort.stall)
      pc <= pc + 1'b1;
  end

endmodule

// File: gpuIfs.sv
`timescale 1ns/100ps
`include "gpu_defines.svh"

////////////////////////////////////////
// sequencer <-> execute

interface uopIf
  import gpuPkg::*;
();
  uop_t             uop;          // combinational from pc
  logic             uopValid;     // engine running
  logic             stall;        // pc held, same uop next cycle
  logic             holdReq;      // execute asks to hold this uop
  logic             jump;         // taken branch
  logic [`PC_W-1:0] jumpTarget;

  modport decode (
    output uop, uopValid, stall,
    input  holdReq, jump, jumpTarget
  );

  modport execute (
    input  uop, uopValid, stall,
    output holdReq, jump, jumpTarget
  );
endinterface

////////////////////////////////////////
// execute <-> register bank

interface regPortIf
  import gpuPkg::*;
();
  gpuReg_t            dst;
  gpuReg_t            src;
  logic [`DATA_W-1:0] result;      // alu output
  logic               regWe;       // write result into dst
  logic               bufWe;       // wbg issued this cycle
  logic               readReq;     // rvmem issued this cycle
  logic [`DATA_W-1:0] srcValue;
  logic [`DATA_W-1:0] dstValue;
  logic               zero;        // flag from last register write

  modport execute (
    output dst, src, result, regWe, bufWe, readReq,
    input  srcValue, dstValue, zero
  );

  modport resultStage (
    input  dst, src, result, regWe, bufWe, readReq,
    output srcValue, dstValue, zero
  );
endinterface

// File: gpuPkg.sv
`include "gpu_defines.svh"

package gpuPkg;

  // engine operations in a 5 bit opcode field
  typedef enum logic [4:0] {
    opNop   = 5'd0,
    opWbg   = 5'd1,    // palette convert bh/bl and push one fb word
    opWrr   = 5'd2,    // register to register
    opWrl   = 5'd3,    // literal into upper bits
    opRvmem = 5'd4,    // vmem read strobe
    opAdd   = 5'd5,
    opAddl  = 5'd6,
    opSubl  = 5'd7,
    opSub   = 5'd8,
    opAnd   = 5'd9,
    opJz    = 5'd10,
    opJnz   = 5'd11,
    opGoto  = 5'd12
  } gpuOp_t;

  // register file map
  // 0..7 line up with the host select codes
  typedef enum logic [4:0] {
    regLcdc     = 5'd0,
    regScy      = 5'd1,
    regScx      = 5'd2,
    regLy       = 5'd3,     // engine owned
    regLyc      = 5'd4,
    regBgp      = 5'd5,
    regWy       = 5'd6,
    regWx       = 5'd7,
    regVmemAddr = 5'd8,     // drives mcuAddr
    regBh       = 5'd9,     // high bitplane
    regBl       = 5'd10,    // low bitplane
    regR0       = 5'd11,
    regR1       = 5'd12,
    regR2       = 5'd13,
    regR3       = 5'd14,
    regFbAddr   = 5'd15,    // read only fb word counter
    regReadData = 5'd16     // read only vmem return byte
  } gpuReg_t;

  ////////////////////////////////////////
  // 20 bit microinstruction word

  typedef struct packed {
    gpuReg_t               src;
    logic [`LIT_W-6:0]     rsvd;     // zero in register forms
  } srcArg_t;

  // register forms and literal forms share the low 10 bits
  typedef union packed {
    srcArg_t               r;
    logic [`LIT_W-1:0]     literal;  // also the jump target
  } uopArg_t;

  typedef struct packed {
    gpuOp_t  op;     // [19:15]
    gpuReg_t dst;    // [14:10]
    uopArg_t arg;    // [9:0]
  } uop_t;

endpackage

// File: gpu_defines.svh
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// datapath widths
`define DATA_W      16             // engine datapath and vmem address
`define BYTE_W      8              // display registers, bitplane bytes
`define FB_ADDR_W   13             // framebuffer word address
`define HOST_SEL_W  4              // host register select
`define PC_W        8
`define LIT_W       10             // literal field, doubles as jump target

// microcode store
`define UCODE_DEPTH 16

// framebuffer flow control
`define FB_CREDITS  2              // credits held right after reset
`define CREDIT_W    2

// program constants
`define VMEM_BASE   16'h8000       // first tile row byte
`define ROW_COUNT   4              // framebuffer words per run

`endif
